//--- verilog/x86_arch_pkg.sv
package x86_arch_pkg;

  // Instruction window in bytes
  // Opcode, ModR/M, SIB, disp32 and imm32 fill it exactly
  localparam int INSTR_BYTES = 11;

  // Same window in bits
  localparam int INSTR_BITS = INSTR_BYTES * 8;

  // General register numbers as encoded in ModR/M, SIB and opcode bits
  typedef enum logic [2:0] {
    EAX = 3'd0,
    ECX = 3'd1,
    EDX = 3'd2,
    EBX = 3'd3,
    ESP = 3'd4,
    EBP = 3'd5,
    ESI = 3'd6,
    EDI = 3'd7
  } reg_num_e;

  // ModR/M byte, mod in the top two bits
  // reg_op is the reg/opcode field
  typedef struct packed {
    logic [1:0] mod;
    reg_num_e   reg_op;
    reg_num_e   rm;
  } modrm_t;

  // SIB byte
  // Index ESP means no index, base EBP with mod 0 means no base
  typedef struct packed {
    logic [1:0] scale;
    reg_num_e   index;
    reg_num_e   base;
  } sib_t;

  // One addressing byte, read as ModR/M or as SIB depending on position
  typedef union packed {
    modrm_t modrm;
    sib_t   sib;
  } addr_byte_u;

  // Eight 32-bit general registers, indexed by register number
  typedef logic [7:0][31:0] reg_file_t;

endpackage

//--- verilog/opnd_pkg.sv
package opnd_pkg;

  import x86_arch_pkg::*;

  // Operand form from the opcode table
  typedef enum logic [3:0] {
    FORM_NONE,
    // opnd0 from opcode low bits
    FORM_REG,
    // opnd0 from opcode low bits, opnd1 immediate
    FORM_REG_IMM,
    // opnd0 EAX, opnd1 immediate
    FORM_EAX_IMM,
    // opnd0 EAX, opnd1 from opcode low bits
    FORM_EAX_REG,
    FORM_RM_REG,
    FORM_REG_RM,
    FORM_RM_IMM,
    // Implicit ESI/EDI operands, no ModR/M
    FORM_STRING
  } opnd_form_e;

  // Decoded command, only the string commands matter here
  typedef enum logic [5:0] {
    CMD_OTHER,
    CMD_MOVS,
    CMD_CMPS,
    CMD_STOS,
    CMD_LODS,
    CMD_SCAS
  } cmd_e;

  // Destination kind, REG and MEM are one-hot
  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_REG  = 2'd1,
    DEST_MEM  = 2'd2
  } dest_kind_e;

  // Memory access hint from the trace
  typedef struct packed {
    logic        is_write;
    logic [31:0] address;
    logic [31:0] data;
  } mem_hint_t;

  // Instruction as presented to the stage
  typedef struct packed {
    logic [INSTR_BITS-1:0] instr;
    cmd_e                  cmd;
    opnd_form_e            form;
    logic                  imm_1byte;
    logic                  opnd0_is_write;
    logic                  opnd1_is_write;
  } decode_in_t;

  // Stage 1 result, parsed instruction fields
  typedef struct packed {
    logic        valid;
    cmd_e        cmd;
    opnd_form_e  form;
    logic        opnd0_is_write;
    logic        opnd1_is_write;
    logic        has_modrm;
    logic        has_sib;
    addr_byte_u  modrm;
    addr_byte_u  sib;
    logic [31:0] disp;
    logic [31:0] imm;
    reg_num_e    opc_reg;
  } fields_t;

  // Stage 2 result, operand values and their sources
  typedef struct packed {
    logic        valid;
    logic [31:0] opnd0;
    logic [31:0] opnd1;
    logic        opnd0_is_reg;
    logic        opnd0_is_mem;
    logic        opnd1_is_reg;
    logic        opnd1_is_mem;
    reg_num_e    opnd0_sel;
    reg_num_e    opnd1_sel;
    logic        opnd0_is_write;
    logic        opnd1_is_write;
  } opnd_t;

  // Final result
  typedef struct packed {
    logic        valid;
    logic [31:0] opnd0;
    logic [31:0] opnd1;
    dest_kind_e  dest0_kind;
    dest_kind_e  dest1_kind;
    logic [31:0] dest0_sel;
    logic [31:0] dest1_sel;
  } opnd_out_t;

endpackage

//--- verilog/instr_fields.sv
`timescale 1ns/10ps

module instr_fields
  import x86_arch_pkg::*, opnd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  decode_in_t in,
  output fields_t    fields
);

  addr_byte_u            modrm_byte;
  addr_byte_u            sib_byte;
  logic                  has_modrm;
  logic                  has_sib;
  logic                  disp8;
  logic                  disp32;
  logic [3:0]            disp_len;
  logic [3:0]            disp_pos;
  logic [3:0]            imm_pos;
  logic [INSTR_BITS-1:0] disp_win;
  logic [INSTR_BITS-1:0] imm_win;
  logic [31:0]           disp;
  logic [31:0]           imm;
  fields_t               fields_d;

  // Byte 0 is the opcode, byte 1 is ModR/M when present
  assign modrm_byte = in.instr[15:8];
  // Byte 2 is only a SIB byte when ModR/M asks for one
  assign sib_byte = in.instr[23:16];

  assign has_modrm = in.form inside {FORM_RM_REG, FORM_REG_RM, FORM_RM_IMM};

  // rm of ESP in a memory mode escapes to SIB
  assign has_sib = has_modrm && (modrm_byte.modrm.mod != 2'b11) &&
                   (modrm_byte.modrm.rm == ESP);

  assign disp8 = has_modrm && (modrm_byte.modrm.mod == 2'b01);

  // mod 0 with rm EBP, or SIB base EBP, means bare disp32
  always_comb begin
    disp32 = 1'b0;
    if (has_modrm) begin
      if (modrm_byte.modrm.mod == 2'b10) begin
        disp32 = 1'b1;
      end else if (modrm_byte.modrm.mod == 2'b00) begin
        disp32 = has_sib ? (sib_byte.sib.base == EBP) : (modrm_byte.modrm.rm == EBP);
      end
    end
  end

  assign disp_len = disp32 ? 4'd4 : (disp8 ? 4'd1 : 4'd0);

  // Displacement follows ModR/M and SIB, immediate follows displacement
  assign disp_pos = 4'd1 + 4'(has_modrm) + 4'(has_sib);
  assign imm_pos = disp_pos + disp_len;

  // Shift the window so each field lands in the low bytes
  assign disp_win = in.instr >> {disp_pos, 3'b000};
  assign imm_win = in.instr >> {imm_pos, 3'b000};

  always_comb begin
    if (disp32) begin
      disp = disp_win[31:0];
    end else if (disp8) begin
      disp = {{24{disp_win[7]}}, disp_win[7:0]};
    end else begin
      disp = 32'd0;
    end
  end

  // Little endian bytes give the value directly, a single byte is sign-extended
  assign imm = in.imm_1byte ? {{24{imm_win[7]}}, imm_win[7:0]} : imm_win[31:0];

  always_comb begin
    fields_d.valid          = in_valid;
    fields_d.cmd            = in.cmd;
    fields_d.form           = in.form;
    fields_d.opnd0_is_write = in.opnd0_is_write;
    fields_d.opnd1_is_write = in.opnd1_is_write;
    fields_d.has_modrm      = has_modrm;
    fields_d.has_sib        = has_sib;
    fields_d.modrm          = has_modrm ? modrm_byte : '0;
    fields_d.sib            = has_sib ? sib_byte : '0;
    fields_d.disp           = disp;
    fields_d.imm            = imm;
    // Register encoded in the opcode's low bits
    fields_d.opc_reg        = reg_num_e'(in.instr[2:0]);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fields <= '0;
    end else begin
      fields <= fields_d;
    end
  end

endmodule

//--- verilog/addr_gen.sv
`timescale 1ns/10ps

module addr_gen
  import x86_arch_pkg::*;
(
  input  reg_file_t   regs,
  input  logic        mode_sib,
  input  addr_byte_u  addr_byte,
  input  addr_byte_u  sib_byte,
  input  logic        base_override,
  input  reg_num_e    base_sel,
  input  logic [31:0] disp,
  output logic [31:0] address
);

  modrm_t      modrm;
  sib_t        sib;
  logic        index_en;
  logic        base_en;
  reg_num_e    base_num;
  logic [31:0] index_val;
  logic [31:0] base_val;

  assign modrm = addr_byte.modrm;
  assign sib = sib_byte.sib;

  // Index only exists with SIB, and index ESP means none
  assign index_en = mode_sib && (sib.index != ESP);

  // Implicit string base wins, then SIB.base, then ModR/M.rm
  assign base_num = base_override ? base_sel : (mode_sib ? sib.base : modrm.rm);

  // mod 0 with EBP as base is the disp32-only encoding
  assign base_en = base_override || (modrm.mod != 2'b00) ||
                   (mode_sib ? (sib.base != EBP) : (modrm.rm != EBP));

  assign index_val = index_en ? (regs[sib.index] << sib.scale) : 32'd0;
  assign base_val = base_en ? regs[base_num] : 32'd0;

  assign address = base_val + index_val + disp;

endmodule

//--- verilog/opnd_fetch.sv
`timescale 1ns/10ps

module opnd_fetch
  import x86_arch_pkg::*, opnd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  fields_t   fields,
  input  reg_file_t regs,
  input  mem_hint_t hint1,
  input  mem_hint_t hint2,
  output opnd_t     opnd
);

  modrm_t      modrm;
  logic        rm_is_reg;
  logic        rm0;
  logic        rm1;
  logic        str0;
  logic        str1;
  reg_num_e    str0_base;
  reg_num_e    str1_base;
  logic        opnd0_is_reg;
  logic        opnd0_is_mem;
  logic        opnd1_is_reg;
  logic        opnd1_is_mem;
  logic        opnd1_is_imm;
  reg_num_e    opnd0_sel;
  reg_num_e    opnd1_sel;
  logic [31:0] addr0;
  logic [31:0] addr1;
  logic [31:0] mem0;
  logic [31:0] mem1;
  opnd_t       opnd_d;

  // Read hints only, first hint has priority
  function automatic logic [31:0] hint_lookup(input logic [31:0] addr,
                                              input mem_hint_t h1,
                                              input mem_hint_t h2);
    if (!h1.is_write && (h1.address == addr)) begin
      return h1.data;
    end else if (!h2.is_write && (h2.address == addr)) begin
      return h2.data;
    end
    return 32'd0;
  endfunction

  assign modrm = fields.modrm.modrm;
  // mod 3 is register direct
  assign rm_is_reg = (modrm.mod == 2'b11);

  // Which operand the rm field feeds
  assign rm0 = fields.form inside {FORM_RM_REG, FORM_RM_IMM};
  assign rm1 = (fields.form == FORM_REG_RM);

  // Implicit bases of the string commands
  always_comb begin
    str0      = 1'b1;
    str0_base = EDI;
    case (fields.cmd)
      CMD_MOVS, CMD_STOS, CMD_SCAS: str0_base = EDI;
      CMD_CMPS:                     str0_base = ESI;
      default:                      str0 = 1'b0;
    endcase
    str1      = 1'b1;
    str1_base = ESI;
    case (fields.cmd)
      CMD_MOVS, CMD_LODS: str1_base = ESI;
      CMD_CMPS:           str1_base = EDI;
      default:            str1 = 1'b0;
    endcase
  end

  // Operand kinds
  assign opnd0_is_reg = (fields.form inside {FORM_REG, FORM_REG_IMM, FORM_EAX_IMM,
                                             FORM_EAX_REG, FORM_REG_RM}) ||
                        (rm0 && rm_is_reg);
  assign opnd0_is_mem = str0 || (rm0 && !rm_is_reg);
  assign opnd1_is_reg = (fields.form inside {FORM_EAX_REG, FORM_RM_REG}) ||
                        (rm1 && rm_is_reg);
  assign opnd1_is_mem = str1 || (rm1 && !rm_is_reg);
  assign opnd1_is_imm = fields.form inside {FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM};

  // Register selectors: opcode bits, reg, rm, then implicit EAX
  always_comb begin
    case (fields.form)
      FORM_REG, FORM_REG_IMM:   opnd0_sel = fields.opc_reg;
      FORM_REG_RM:              opnd0_sel = modrm.reg_op;
      FORM_RM_REG, FORM_RM_IMM: opnd0_sel = modrm.rm;
      default:                  opnd0_sel = EAX;
    endcase
    case (fields.form)
      FORM_EAX_REG: opnd1_sel = fields.opc_reg;
      FORM_RM_REG:  opnd1_sel = modrm.reg_op;
      FORM_REG_RM:  opnd1_sel = modrm.rm;
      default:      opnd1_sel = EAX;
    endcase
  end

  // One address per operand since string commands use two bases
  addr_gen a0 (
    .regs          (regs),
    .mode_sib      (fields.has_sib),
    .addr_byte     (fields.modrm),
    .sib_byte      (fields.sib),
    .base_override (str0),
    .base_sel      (str0_base),
    .disp          (fields.disp),
    .address       (addr0)
  );

  addr_gen a1 (
    .regs          (regs),
    .mode_sib      (fields.has_sib),
    .addr_byte     (fields.modrm),
    .sib_byte      (fields.sib),
    .base_override (str1),
    .base_sel      (str1_base),
    .disp          (fields.disp),
    .address       (addr1)
  );

  assign mem0 = hint_lookup(addr0, hint1, hint2);
  assign mem1 = hint_lookup(addr1, hint1, hint2);

  always_comb begin
    opnd_d.valid          = fields.valid;
    opnd_d.opnd0          = opnd0_is_reg ? regs[opnd0_sel] :
                            opnd0_is_mem ? mem0 : 32'd0;
    opnd_d.opnd1          = opnd1_is_reg ? regs[opnd1_sel] :
                            opnd1_is_mem ? mem1 :
                            opnd1_is_imm ? fields.imm : 32'd0;
    opnd_d.opnd0_is_reg   = opnd0_is_reg;
    opnd_d.opnd0_is_mem   = opnd0_is_mem;
    opnd_d.opnd1_is_reg   = opnd1_is_reg;
    opnd_d.opnd1_is_mem   = opnd1_is_mem;
    opnd_d.opnd0_sel      = opnd0_sel;
    opnd_d.opnd1_sel      = opnd1_sel;
    opnd_d.opnd0_is_write = fields.opnd0_is_write;
    opnd_d.opnd1_is_write = fields.opnd1_is_write;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opnd <= '0;
    end else begin
      opnd <= opnd_d;
    end
  end

endmodule

//--- verilog/dest_encode.sv
`timescale 1ns/10ps

module dest_encode
  import opnd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  opnd_t     opnd,
  output opnd_out_t out
);

  logic       write0;
  logic       write1;
  dest_kind_e kind0;
  dest_kind_e kind1;
  opnd_out_t  out_d;

  // Written register goes to REG, anything else written goes to memory
  function automatic dest_kind_e dest_kind(input logic written, input logic is_reg);
    if (!written) begin
      return DEST_NONE;
    end
    return is_reg ? DEST_REG : DEST_MEM;
  endfunction

  // Bubbles carry no destination
  assign write0 = opnd.valid && opnd.opnd0_is_write;
  assign write1 = opnd.valid && opnd.opnd1_is_write;

  assign kind0 = dest_kind(write0, opnd.opnd0_is_reg);
  assign kind1 = dest_kind(write1, opnd.opnd1_is_reg);

  always_comb begin
    out_d.valid      = opnd.valid;
    out_d.opnd0      = opnd.opnd0;
    out_d.opnd1      = opnd.opnd1;
    out_d.dest0_kind = kind0;
    out_d.dest1_kind = kind1;
    // Selector only names a register for register destinations
    out_d.dest0_sel  = (kind0 == DEST_REG) ? {29'd0, opnd.opnd0_sel} : 32'd0;
    out_d.dest1_sel  = (kind1 == DEST_REG) ? {29'd0, opnd.opnd1_sel} : 32'd0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out <= '0;
    end else begin
      out <= out_d;
    end
  end

endmodule

//--- verilog/opnd_decode_top.sv
`timescale 1ns/10ps

module opnd_decode_top
  import x86_arch_pkg::*, opnd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  decode_in_t in,
  input  reg_file_t  regs,
  input  mem_hint_t  hint1,
  input  mem_hint_t  hint2,
  output opnd_out_t  out
);

  // Stage registers between the three stages
  fields_t fields_q;
  opnd_t   opnd_q;

  // Parse bytes into fields
  instr_fields u_instr_fields (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in       (in),
    .fields   (fields_q)
  );

  // Registers, addresses and hints sampled here
  opnd_fetch u_opnd_fetch (
    .clk    (clk),
    .rst_n  (rst_n),
    .fields (fields_q),
    .regs   (regs),
    .hint1  (hint1),
    .hint2  (hint2),
    .opnd   (opnd_q)
  );

  dest_encode u_dest_encode (
    .clk   (clk),
    .rst_n (rst_n),
    .opnd  (opnd_q),
    .out   (out)
  );

endmodule

//--- bench/opnd_vectors.svh
  // Instruction table, one row per case
  task automatic load_vectors();
    // Columns: name, instruction bytes (byte 0 lowest), cmd, form, imm_1byte,
    // opnd0 write, opnd1 write, then expected opnd0, opnd1, kinds and selectors
    add_vec("inc ecx", 88'h41, CMD_OTHER, FORM_REG, 0, 1, 0,
            32'h0000_00B8, 32'h0000_0000, DEST_REG, DEST_NONE, 1, 0);
    add_vec("mov ebx, edx", 88'hD3_89, CMD_OTHER, FORM_RM_REG, 0, 1, 0,
            32'h1000_0300, 32'h1000_0200, DEST_REG, DEST_NONE, 3, 0);
    add_vec("xchg esi, ecx", 88'hF1_87, CMD_OTHER, FORM_REG_RM, 0, 1, 1,
            32'h1000_0600, 32'h0000_00B8, DEST_REG, DEST_REG, 6, 1);
    add_vec("xchg eax, edi", 88'h97, CMD_OTHER, FORM_EAX_REG, 0, 1, 1,
            32'h1000_0000, 32'h1000_0608, DEST_REG, DEST_REG, 0, 7);
    // EBP + 8 matches no hint
    add_vec("ebp disp8 miss", 88'h08_45_8B, CMD_OTHER, FORM_REG_RM, 0, 1, 0,
            32'h1000_0000, 32'h0000_0000, DEST_REG, DEST_NONE, 0, 0);
    add_vec("esi disp8 store", 88'h08_4E_89, CMD_OTHER, FORM_RM_REG, 0, 1, 0,
            32'hAAAA_1111, 32'h0000_00B8, DEST_MEM, DEST_NONE, 0, 0);
    add_vec("disp32 no base", 88'h10_00_06_00_1D_8B, CMD_OTHER, FORM_REG_RM, 0, 1, 0,
            32'h1000_0300, 32'hBBBB_2222, DEST_REG, DEST_NONE, 3, 0);
    // EBX + 4*ECX + 0x20
    add_vec("sib scaled index", 88'h20_8B_54_8B, CMD_OTHER, FORM_REG_RM, 0, 1, 0,
            32'h1000_0200, 32'hBBBB_2222, DEST_REG, DEST_NONE, 2, 0);
    add_vec("sib no index", 88'h08_E6_44_89, CMD_OTHER, FORM_RM_REG, 0, 1, 0,
            32'hAAAA_1111, 32'h1000_0000, DEST_MEM, DEST_NONE, 0, 0);
    add_vec("sib disp32 only", 88'h10_00_06_08_25_34_8B, CMD_OTHER, FORM_REG_RM, 0, 1, 0,
            32'h1000_0600, 32'hAAAA_1111, DEST_REG, DEST_NONE, 6, 0);
    add_vec("imm8 sign extend", 88'hF0_C2_83, CMD_OTHER, FORM_RM_IMM, 1, 1, 0,
            32'h1000_0200, 32'hFFFF_FFF0, DEST_REG, DEST_NONE, 2, 0);
    add_vec("mov ecx, imm32", 88'h12_34_56_78_B9, CMD_OTHER, FORM_REG_IMM, 0, 1, 0,
            32'h0000_00B8, 32'h1234_5678, DEST_REG, DEST_NONE, 1, 0);
    add_vec("cmp eax, imm32", 88'hDE_AD_BE_EF_3D, CMD_OTHER, FORM_EAX_IMM, 0, 0, 0,
            32'h1000_0000, 32'hDEAD_BEEF, DEST_NONE, DEST_NONE, 0, 0);
    // Displacement then immediate
    add_vec("disp32 and imm32", 88'hCA_FE_00_01_00_00_00_08_86_C7, CMD_OTHER, FORM_RM_IMM,
            0, 1, 0, 32'hAAAA_1111, 32'hCAFE_0001, DEST_MEM, DEST_NONE, 0, 0);
    // EDI hits hint1, ESI hits hint2
    add_vec("movs", 88'hA5, CMD_MOVS, FORM_STRING, 0, 1, 0,
            32'hAAAA_1111, 32'hBBBB_2222, DEST_MEM, DEST_NONE, 0, 0);
    add_vec("stos", 88'hAB, CMD_STOS, FORM_STRING, 0, 1, 0,
            32'hAAAA_1111, 32'h0000_0000, DEST_MEM, DEST_NONE, 0, 0);
    add_vec("lods", 88'hAD, CMD_LODS, FORM_STRING, 0, 0, 0,
            32'h0000_0000, 32'hBBBB_2222, DEST_NONE, DEST_NONE, 0, 0);
    add_vec("cmps", 88'hA7, CMD_CMPS, FORM_STRING, 0, 0, 0,
            32'hBBBB_2222, 32'hAAAA_1111, DEST_NONE, DEST_NONE, 0, 0);
    // CMPS again with hint1 turned into a write at ESI
    write_vec = make_vec(88'hA7, CMD_CMPS, FORM_STRING, 0, 0, 0,
                         32'hBBBB_2222, 32'h0000_0000, DEST_NONE, DEST_NONE, 0, 0);
  endtask

//--- bench/opnd_decode_tb.sv
`timescale 1ns/10ps

module opnd_decode_tb
  import x86_arch_pkg::*, opnd_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  localparam int TIMEOUT_CYCLES = 10;
  // Edges from in_valid sampled to out.valid
  localparam int PIPE_DEPTH = 3;
  localparam logic [31:0] HINT1_DATA = 32'hAAAA_1111;
  localparam logic [31:0] HINT2_DATA = 32'hBBBB_2222;

  // One table row, stimulus then expected response
  typedef struct packed {
    logic [INSTR_BITS-1:0] instr;
    cmd_e                  cmd;
    opnd_form_e            form;
    logic                  imm_1byte;
    logic                  w0;
    logic                  w1;
    logic [31:0]           opnd0;
    logic [31:0]           opnd1;
    dest_kind_e            kind0;
    dest_kind_e            kind1;
    logic [31:0]           sel0;
    logic [31:0]           sel1;
  } vec_t;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  decode_in_t dec_in;
  reg_file_t  regs;
  mem_hint_t  hint1;
  mem_hint_t  hint2;
  opnd_out_t  dec_out;

  vec_t  vecs[$];
  string names[$];
  vec_t  write_vec;
  vec_t  expect_q[$];
  int    errors;
  int    tests_run;
  int    tests_failed;

  opnd_decode_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in       (dec_in),
    .regs     (regs),
    .hint1    (hint1),
    .hint2    (hint2),
    .out      (dec_out)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic vec_t make_vec(input logic [INSTR_BITS-1:0] instr, input cmd_e cmd,
                                    input opnd_form_e form, input logic imm_1byte,
                                    input logic w0, input logic w1,
                                    input logic [31:0] opnd0, input logic [31:0] opnd1,
                                    input dest_kind_e kind0, input dest_kind_e kind1,
                                    input logic [31:0] sel0, input logic [31:0] sel1);
    vec_t v;
    v.instr     = instr;
    v.cmd       = cmd;
    v.form      = form;
    v.imm_1byte = imm_1byte;
    v.w0        = w0;
    v.w1        = w1;
    v.opnd0     = opnd0;
    v.opnd1     = opnd1;
    v.kind0     = kind0;
    v.kind1     = kind1;
    v.sel0      = sel0;
    v.sel1      = sel1;
    return v;
  endfunction

  task automatic add_vec(input string name, input logic [INSTR_BITS-1:0] instr, input cmd_e cmd,
                         input opnd_form_e form, input logic imm_1byte,
                         input logic w0, input logic w1,
                         input logic [31:0] opnd0, input logic [31:0] opnd1,
                         input dest_kind_e kind0, input dest_kind_e kind1,
                         input logic [31:0] sel0, input logic [31:0] sel1);
    vecs.push_back(make_vec(instr, cmd, form, imm_1byte, w0, w1,
                            opnd0, opnd1, kind0, kind1, sel0, sel1));
    names.push_back(name);
  endtask

  `include "opnd_vectors.svh"

  task automatic drive_row(input vec_t v);
    in_valid              = 1'b1;
    dec_in.instr          = v.instr;
    dec_in.cmd            = v.cmd;
    dec_in.form           = v.form;
    dec_in.imm_1byte      = v.imm_1byte;
    dec_in.opnd0_is_write = v.w0;
    dec_in.opnd1_is_write = v.w1;
  endtask

  task automatic clear_input();
    in_valid = 1'b0;
    dec_in   = '0;
  endtask

  task automatic compare_out(input vec_t v);
    check_word("out.opnd0", v.opnd0, dec_out.opnd0);
    check_word("out.opnd1", v.opnd1, dec_out.opnd1);
    check_word("out.dest0_kind", 32'(v.kind0), 32'(dec_out.dest0_kind));
    check_word("out.dest1_kind", 32'(v.kind1), 32'(dec_out.dest1_kind));
    check_word("out.dest0_sel", v.sel0, dec_out.dest0_sel);
    check_word("out.dest1_sel", v.sel1, dec_out.dest1_sel);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %-20s ok", name);
    end else begin
      tests_failed++;
      $display("test %-20s %0d errors", name, errors - errs_before);
    end
  endtask

  // Outputs must be idle while rst_n is low
  task automatic verify_reset();
    int errs_before;
    errs_before = errors;
    check_word("out.valid", 32'd0, 32'(dec_out.valid));
    check_word("out.dest0_kind", 32'(DEST_NONE), 32'(dec_out.dest0_kind));
    check_word("out.dest1_kind", 32'(DEST_NONE), 32'(dec_out.dest1_kind));
    check_word("out.dest0_sel", 32'd0, dec_out.dest0_sel);
    check_word("out.dest1_sel", 32'd0, dec_out.dest1_sel);
    report_test("reset", errs_before);
  endtask

  // Single instruction, entered 1 ns after an edge
  task automatic run_row(input vec_t v, input string name);
    int errs_before;
    int edges;
    bit seen;
    errs_before = errors;
    edges = 0;
    seen = 1'b0;
    drive_row(v);
    while (!seen && edges < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      edges++;
      clear_input();
      seen = dec_out.valid;
    end
    if (!seen) begin
      $display("Timeout at %0t: out.valid never rose for %s", $time, name);
      errors++;
    end else begin
      if (edges != PIPE_DEPTH) begin
        $display("FAILED at %0t: out.valid edge expected %0d actual %0d",
                 $time, PIPE_DEPTH, edges);
        errors++;
      end
      compare_out(v);
    end
    report_test(name, errs_before);
  endtask

  // All rows on consecutive cycles, three in flight at once
  task automatic stream_rows();
    int errs_before;
    int sent;
    int got;
    int edges;
    vec_t exp;
    errs_before = errors;
    sent = 0;
    got = 0;
    edges = 0;
    expect_q.delete();
    while (got < vecs.size() && edges < vecs.size() + TIMEOUT_CYCLES) begin
      if (sent < vecs.size()) begin
        drive_row(vecs[sent]);
        expect_q.push_back(vecs[sent]);
        sent++;
      end else begin
        clear_input();
      end
      @(posedge clk);
      #1;
      edges++;
      if (dec_out.valid) begin
        if (expect_q.size() == 0) begin
          $display("Unexpected out.valid at %0t with nothing in flight", $time);
          errors++;
        end else begin
          exp = expect_q.pop_front();
          // Row k is sampled on edge k+1 and leaves on edge k+3
          if (edges != got + PIPE_DEPTH) begin
            $display("FAILED at %0t: out.valid edge expected %0d actual %0d",
                     $time, got + PIPE_DEPTH, edges);
            errors++;
          end
          compare_out(exp);
          got++;
        end
      end
    end
    clear_input();
    if (got < vecs.size()) begin
      $display("Timeout at %0t: only %0d of %0d rows came out", $time, got, vecs.size());
      errors++;
    end
    report_test("back to back", errs_before);
  endtask

  initial begin
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    clear_input();
    for (int i = 0; i < 8; i++) begin
      regs[i] = 32'h1000_0000 + 32'h100 * i;
    end
    // ECX puts hint2 on ESI, EDI sits on hint1
    regs[ECX] = 32'h0000_00B8;
    regs[EDI] = 32'h1000_0608;
    hint1.is_write = 1'b0;
    hint1.address  = regs[ESI] + 32'd8;
    hint1.data     = HINT1_DATA;
    hint2.is_write = 1'b0;
    hint2.address  = regs[EBX] + (regs[ECX] << 2) + 32'h20;
    hint2.data     = HINT2_DATA;
    load_vectors();

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    verify_reset();
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    foreach (vecs[i]) begin
      run_row(vecs[i], names[i]);
    end
    stream_rows();

    // Same address as hint2 but flagged as a write
    hint1.is_write = 1'b1;
    hint1.address  = regs[ESI];
    hint1.data     = 32'h5555_5555;
    run_row(write_vec, "write hint ignored");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+bench
verilog/x86_arch_pkg.sv
verilog/opnd_pkg.sv
verilog/instr_fields.sv
verilog/addr_gen.sv
verilog/opnd_fetch.sv
verilog/dest_encode.sv
verilog/opnd_decode_top.sv
bench/opnd_decode_tb.sv

//--- Bender.yml
package:
  name: opnd_decode

sources:
  - verilog/x86_arch_pkg.sv
  - verilog/opnd_pkg.sv
  - verilog/instr_fields.sv
  - verilog/addr_gen.sv
  - verilog/opnd_fetch.sv
  - verilog/dest_encode.sv
  - verilog/opnd_decode_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/opnd_decode_tb.sv
